// File: Makefile
VERILATOR  ?= verilator
TOP        ?= cache_memctrl_tb
FILELIST   ?= cache_memctrl_top.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: cache_memctrl_top.f
+incdir+include
source/memctrl_pkg.sv
source/sync_sram.sv
source/wb_req_port.sv
source/dir_ctrl.sv
source/data_ctrl.sv
source/wb_resp_port.sv
source/cache_memctrl_top.sv
dv/cache_memctrl_tb.sv

// File: dv/cache_memctrl_tb.sv
/* Testbench of the cache controller: clock, reset, stimulus table,
   value check, per-test report and watchdog */

module cache_memctrl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SETS         = 16;
    localparam int unsigned RESET_CYCLES = 10;
    localparam int unsigned TIMING_TEST  = 6;

    // One bus transfer and what it must return
    typedef struct packed {
        logic [2:0]  test;
        logic        we;
        logic [7:0]  tag;
        logic [3:0]  set;
        logic [1:0]  word;
        logic [31:0] wdata;
        logic        exp_err;
        logic [31:0] exp_rdata;
    } entry_t;

    logic        clk_i;
    logic        rst_ni;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [13:0] wb_adr;
    logic [31:0] wb_dat;
    logic        wb_ack;
    logic        wb_err;
    logic [31:0] wb_rdat;

    entry_t table_q [$];
    logic   table_built = 1'b0;
    int     test_errs [1:6] = '{default: 0};
    int     total_checks = 0;
    int     total_errs = 0;
    int     tests_failed = 0;

    cache_memctrl_top i_cache_memctrl_top (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat),
        .wb_ack_o (wb_ack),
        .wb_err_o (wb_err),
        .wb_dat_o (wb_rdat)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic string test_name(input int test);
        case (test)
            1:       return "access before init and read miss";
            2:       return "write then read";
            3:       return "partial line overwrite";
            4:       return "round robin eviction";
            5:       return "word and set independence";
            default: return "response timing";
        endcase
    endfunction

    task automatic check_value(input int test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        total_checks++;
        if (actual !== expected) begin
            test_errs[test]++;
            total_errs++;
            $display("Error: %s, %s: expected %h, actual %h",
                     test_name(test), what, expected, actual);
        end
    endtask

    task automatic add_write(input int test, input logic [7:0] tag, input logic [3:0] set,
                             input logic [1:0] word, input logic [31:0] data);
        table_q.push_back('{3'(test), 1'b1, tag, set, word, data, 1'b0, 32'h0});
    endtask

    task automatic add_read(input int test, input logic [7:0] tag, input logic [3:0] set,
                            input logic [1:0] word, input logic err, input logic [31:0] data);
        table_q.push_back('{3'(test), 1'b0, tag, set, word, 32'h0, err, data});
    endtask

    task automatic build_table();
        int i;
        // Nothing is valid yet, the first read waits for the sweep
        add_read(1, 8'h11, 4'd0, 2'd0, 1'b1, 32'h0);
        add_read(1, 8'h5a, 4'd5, 2'd3, 1'b1, 32'h0);
        add_read(1, 8'hff, 4'd15, 2'd2, 1'b1, 32'h0);
        add_write(2, 8'h11, 4'd1, 2'd0, 32'h1111_0100);
        add_read(2, 8'h11, 4'd1, 2'd0, 1'b0, 32'h1111_0100);
        // Two tags share set 2, then tag a0 word 1 is overwritten
        add_write(3, 8'ha0, 4'd2, 2'd1, 32'ha0a0_0001);
        add_write(3, 8'hb0, 4'd2, 2'd1, 32'hb0b0_0001);
        add_write(3, 8'ha0, 4'd2, 2'd2, 32'ha0a0_0002);
        add_write(3, 8'ha0, 4'd2, 2'd1, 32'ha0a0_1111);
        add_read(3, 8'ha0, 4'd2, 2'd1, 1'b0, 32'ha0a0_1111);
        add_read(3, 8'ha0, 4'd2, 2'd2, 1'b0, 32'ha0a0_0002);
        add_read(3, 8'hb0, 4'd2, 2'd1, 1'b0, 32'hb0b0_0001);
        // Fifth tag wraps the pointer back to the way of tag 31
        for (i = 0; i < 5; i++) begin
            add_write(4, 8'h31 + 8'(i), 4'd7, 2'd0, 32'h7700_0000 + 32'(i));
        end
        add_read(4, 8'h31, 4'd7, 2'd0, 1'b1, 32'h0);
        for (i = 1; i < 5; i++) begin
            add_read(4, 8'h31 + 8'(i), 4'd7, 2'd0, 1'b0, 32'h7700_0000 + 32'(i));
        end
        for (i = 0; i < 4; i++) begin
            add_write(5, 8'h40, 4'd9, 2'(i), 32'h5900_0000 + 32'(i));
        end
        add_write(5, 8'h40, 4'd10, 2'd2, 32'h5a00_0002);
        add_write(5, 8'h40, 4'd9, 2'd2, 32'h5900_0222);
        for (i = 0; i < 4; i++) begin
            add_read(5, 8'h40, 4'd9, 2'(i), 1'b0,
                     (i == 2) ? 32'h5900_0222 : 32'h5900_0000 + 32'(i));
        end
        add_read(5, 8'h40, 4'd10, 2'd2, 1'b0, 32'h5a00_0002);
    endtask

    // Drive one transfer and hold it until ack or err
    task automatic run_transfer(input entry_t e, input logic after_reset);
        int          edges;
        int          ack_cnt;
        int          err_cnt;
        logic [31:0] rdata;
        @(posedge clk_i);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= e.we;
        wb_adr <= {e.tag, e.set, e.word};
        wb_dat <= e.wdata;
        edges = 0;
        do begin
            @(posedge clk_i);
            edges++;
            @(negedge clk_i);
        end while (!(wb_ack || wb_err));
        ack_cnt = wb_ack ? 1 : 0;
        err_cnt = wb_err ? 1 : 0;
        rdata   = wb_rdat;
        // Sampling edge of the master
        @(posedge clk_i);
        edges++;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        @(negedge clk_i);
        check_value(TIMING_TEST, "ack plus err count", 32'd1, 32'(ack_cnt + err_cnt));
        check_value(TIMING_TEST, "response longer than one cycle", 32'd0,
                    32'(wb_ack || wb_err));
        if (after_reset) begin
            check_value(1, "completed after init sweep", 32'd1, (edges > SETS) ? 32'd1 : 32'd0);
        end else begin
            check_value(TIMING_TEST, "edges from accept to sample", 32'd2, 32'(edges - 1));
        end
        check_value(e.test, "err flag", 32'(e.exp_err), 32'(err_cnt));
        if (!e.we && !e.exp_err) begin
            check_value(e.test, "read data", e.exp_rdata, rdata);
        end
    endtask

    task automatic report_test(input int test);
        if (test_errs[test] == 0) begin
            $display("Test %0d %s: pass", test, test_name(test));
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", test, test_name(test), test_errs[test]);
        end
    endtask

    initial begin
        int i;
        rst_ni = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wb_adr = '0;
        wb_dat = '0;
        build_table();
        table_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (i = 0; i < table_q.size(); i++) begin
            run_transfer(table_q[i], i == 0);
            if ((i == table_q.size() - 1) || (table_q[i + 1].test != table_q[i].test)) begin
                report_test(int'(table_q[i].test));
            end
        end
        report_test(TIMING_TEST);
        $display("Summary: %0d transfers, %0d checks, %0d errors, %0d of 6 tests failing",
                 table_q.size(), total_checks, total_errs, tests_failed);
        if (total_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Budget of ten cycles per transfer plus reset and sweep
    initial begin
        int limit;
        wait (table_built);
        limit = table_q.size() * 10 + RESET_CYCLES + SETS;
        repeat (limit) @(posedge clk_i);
        $display("Timeout: the DUT did not finish all transfers within %0d cycles", limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: include/memctrl_settings.svh
/* Geometry macros of the cache directory and data memory controller
   Ways, sets, words per line, tag and data widths */

`ifndef MEMCTRL_SETTINGS_SVH
`define MEMCTRL_SETTINGS_SVH

// Associativity
`define MC_WAYS 4

// Sets per way, one directory entry each
`define MC_SETS 16

// Words per cache line
`define MC_LINE_WORDS 4

`define MC_TAG_W 8
`define MC_DATA_W 32

`endif

// File: source/cache_memctrl_top.sv
/* Top level of the cache controller: request port, directory,
   data memories and response port */

module cache_memctrl_top
    import memctrl_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  wb_adr_t    wb_adr_i,
    input  data_word_t wb_dat_i,
    output logic       wb_ack_o,
    output logic       wb_err_o,
    output data_word_t wb_dat_o
);

    mem_req_t              req;
    logic                  lookup;
    logic                  resp;
    logic                  ready;
    lookup_t               lookup_res;
    data_word_t [WAYS-1:0] way_words;

    wb_req_port i_wb_req_port (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .ready_i  (ready),
        .req_o    (req),
        .lookup_o (lookup),
        .resp_o   (resp)
    );

    dir_ctrl i_dir_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (req),
        .lookup_i     (lookup),
        .resp_i       (resp),
        .ready_o      (ready),
        .lookup_res_o (lookup_res)
    );

    data_ctrl i_data_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (req),
        .lookup_i     (lookup),
        .resp_i       (resp),
        .lookup_res_i (lookup_res),
        .way_words_o  (way_words)
    );

    wb_resp_port i_wb_resp_port (
        .resp_i       (resp),
        .req_i        (req),
        .lookup_res_i (lookup_res),
        .way_words_i  (way_words),
        .wb_ack_o     (wb_ack_o),
        .wb_err_o     (wb_err_o),
        .wb_dat_o     (wb_dat_o)
    );

endmodule

// File: source/data_ctrl.sv
/* Data memory controller: one data RAM per way, word addressing,
   parallel reads and single-way word writes */

module data_ctrl
    import memctrl_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  mem_req_t              req_i,
    input  logic                  lookup_i,
    input  logic                  resp_i,
    input  lookup_t               lookup_res_i,
    output data_word_t [WAYS-1:0] way_words_o
);

    localparam int unsigned DEPTH  = SETS * LINE_WORDS;
    localparam int unsigned ADDR_W = $clog2(DEPTH);

    logic [ADDR_W-1:0] data_addr;
    way_vec_t          data_cs;
    way_vec_t          data_we;
    logic              wr;

    // Line base plus word offset
    assign data_addr = ADDR_W'(req_i.set) * ADDR_W'(LINE_WORDS) + ADDR_W'(req_i.word);

    assign wr      = resp_i && req_i.we;
    assign data_we = wr ? lookup_res_i.way : '0;
    assign data_cs = lookup_i ? '1 : data_we;

    for (genvar w = 0; w < WAYS; w++) begin : gen_data_way
        sync_sram #(
            .payload_t (data_word_t),
            .DEPTH     (DEPTH)
        ) i_data_sram (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .cs_i    (data_cs[w]),
            .we_i    (data_we[w]),
            .addr_i  (data_addr),
            .wdata_i (req_i.data),
            .rdata_o (way_words_o[w])
        );
    end

    write_way_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr |-> $onehot(lookup_res_i.way))
        else $error("write way is not one-hot");

endmodule

// File: source/dir_ctrl.sv
/* Directory controller: init sweep, directory RAMs per way, tag compare,
   round-robin victim pointers and allocation on write misses */

module dir_ctrl
    import memctrl_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  mem_req_t req_i,
    input  logic     lookup_i,
    input  logic     resp_i,
    output logic     ready_o,
    output lookup_t  lookup_res_o
);

    localparam int unsigned PTR_W = $clog2(WAYS);

    typedef logic [PTR_W-1:0] ptr_t;

    logic                  init_done_q;
    set_t                  init_set_q;
    ptr_t [SETS-1:0]       rr_q;
    set_t                  dir_addr;
    way_vec_t              dir_cs;
    way_vec_t              dir_we;
    dir_entry_t            dir_wentry;
    dir_entry_t [WAYS-1:0] dir_rentry;
    way_vec_t              hit_vec;
    way_vec_t              victim_vec;
    logic                  hit;
    logic                  alloc;

    // Clear one set per cycle after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_done_q <= 1'b0;
            init_set_q  <= '0;
        end else if (!init_done_q) begin
            init_set_q  <= init_set_q + 1'b1;
            init_done_q <= (init_set_q == set_t'(SETS - 1));
        end
    end

    assign ready_o = init_done_q;

    always_comb begin
        dir_addr   = req_i.set;
        dir_cs     = '0;
        dir_we     = '0;
        dir_wentry = '{valid: 1'b1, tag: req_i.tag};
        if (!init_done_q) begin
            dir_addr   = init_set_q;
            dir_cs     = '1;
            dir_we     = '1;
            dir_wentry = '0;
        end else if (lookup_i) begin
            dir_cs = '1;
        end else if (alloc) begin
            dir_cs = victim_vec;
            dir_we = victim_vec;
        end
    end

    for (genvar w = 0; w < WAYS; w++) begin : gen_dir_way
        sync_sram #(
            .payload_t (dir_entry_t),
            .DEPTH     (SETS)
        ) i_dir_sram (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .cs_i    (dir_cs[w]),
            .we_i    (dir_we[w]),
            .addr_i  (dir_addr),
            .wdata_i (dir_wentry),
            .rdata_o (dir_rentry[w])
        );

        assign hit_vec[w] = dir_rentry[w].valid && (dir_rentry[w].tag == req_i.tag);
    end

    assign hit        = |hit_vec;
    assign victim_vec = way_vec_t'(1) << rr_q[req_i.set];
    assign alloc      = resp_i && req_i.we && !hit;

    assign lookup_res_o = '{hit: hit, way: hit ? hit_vec : victim_vec};

    // Pointer moves only when its way has been taken
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q <= '0;
        end else if (alloc) begin
            rr_q[req_i.set] <= rr_q[req_i.set] + 1'b1;
        end
    end

    hit_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resp_i |-> $onehot0(hit_vec))
        else $error("tag present in more than one way");

endmodule

// File: source/memctrl_pkg.sv
/* Package with the geometry constants and the shared types:
   addresses, directory entries, captured requests and lookup results */

`include "memctrl_settings.svh"

package memctrl_pkg;

    localparam int unsigned WAYS       = `MC_WAYS;
    localparam int unsigned SETS       = `MC_SETS;
    localparam int unsigned LINE_WORDS = `MC_LINE_WORDS;

    typedef logic [WAYS-1:0]               way_vec_t;
    typedef logic [$clog2(SETS)-1:0]       set_t;
    typedef logic [$clog2(LINE_WORDS)-1:0] word_idx_t;
    typedef logic [`MC_TAG_W-1:0]          tag_t;
    typedef logic [`MC_DATA_W-1:0]         data_word_t;

    // Word address as seen on the bus
    typedef struct packed {
        tag_t      tag;
        set_t      set;
        word_idx_t word;
    } wb_adr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } dir_entry_t;

    // Request held for the whole transfer
    typedef struct packed {
        logic       we;
        tag_t       tag;
        set_t       set;
        word_idx_t  word;
        data_word_t data;
    } mem_req_t;

    // Hit way, or the victim way on a miss
    typedef struct packed {
        logic     hit;
        way_vec_t way;
    } lookup_t;

endpackage

// File: source/sync_sram.sv
/* Single-port synchronous RAM with a generic payload type */

module sync_sram
    import memctrl_pkg::*;
#(
    parameter type         payload_t = data_word_t,
    parameter int unsigned DEPTH     = 16
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     cs_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  payload_t                 wdata_i,
    output payload_t                 rdata_o
);

    payload_t mem_q [DEPTH];

    always_ff @(posedge clk_i) begin
        if (cs_i && we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
    end

    // Read port holds its value until the next read
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_o <= '0;
        end else if (cs_i && !we_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

// File: source/wb_req_port.sv
/* Wishbone request side: transfer acceptance, request capture
   and the idle, lookup, respond sequencer */

module wb_req_port
    import memctrl_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  wb_adr_t    wb_adr_i,
    input  data_word_t wb_dat_i,
    input  logic       ready_i,
    output mem_req_t   req_o,
    output logic       lookup_o,
    output logic       resp_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_RESP
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   accept;

    assign accept = wb_cyc_i && wb_stb_i && ready_i && (state_q == ST_IDLE);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: state_d = ST_RESP;
            ST_RESP:   state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request fields taken at acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_o <= '{we:   wb_we_i,
                       tag:  wb_adr_i.tag,
                       set:  wb_adr_i.set,
                       word: wb_adr_i.word,
                       data: wb_dat_i};
        end
    end

    assign lookup_o = (state_q == ST_LOOKUP);
    assign resp_o   = (state_q == ST_RESP);

    accept_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (lookup_o || resp_o) |-> ready_i)
        else $error("transfer in flight while directory not ready");

endmodule

// File: source/wb_resp_port.sv
/* Wishbone response side: ack and err generation and hit way word select */

module wb_resp_port
    import memctrl_pkg::*;
(
    input  logic                  resp_i,
    input  mem_req_t              req_i,
    input  lookup_t               lookup_res_i,
    input  data_word_t [WAYS-1:0] way_words_i,
    output logic                  wb_ack_o,
    output logic                  wb_err_o,
    output data_word_t            wb_dat_o
);

    logic rd_hit;

    // Writes always complete, read misses fail
    assign wb_ack_o = resp_i && (req_i.we || lookup_res_i.hit);
    assign wb_err_o = resp_i && !req_i.we && !lookup_res_i.hit;
    assign rd_hit   = resp_i && !req_i.we && lookup_res_i.hit;

    // AND-OR select over the one-hot hit way
    always_comb begin
        wb_dat_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (rd_hit && lookup_res_i.way[w]) begin
                wb_dat_o = wb_dat_o | way_words_i[w];
            end
        end
    end

endmodule
